// File: files.f
+incdir+hdl
hdl/core_pkg.sv
hdl/pipe_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/rv_core.sv
sim/tb_rv_core.sv

// File: Makefile
# Verilator build and run for the pipelined core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module tb_rv_core;

    localparam int WORDS   = 12;
    localparam int TIMEOUT = 200;

    logic             clk        = 1'b0;
    logic             reset      = 1'b1;
    logic             imem_req;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_data  = `NOP_INST;
    logic             dmem_read;
    logic             dmem_write;
    logic [`XLEN-1:0] dmem_addr;
    logic [`XLEN-1:0] dmem_wdata;
    logic [`XLEN-1:0] dmem_rdata = '0;

    // program rows, padded with nops
    logic [31:0] prog [16][WORDS];
    logic [31:0] exp_addr [16];
    logic [31:0] exp_data [16];
    int          n_rows;
    int          n_words;

    logic [31:0] rom [64];
    logic [31:0] ram [64];

    // dut outputs taken mid cycle
    logic        rst_s     = 1'b1;
    logic        i_req_s   = 1'b0;
    logic [31:0] i_addr_s  = '0;
    logic        d_read_s  = 1'b0;
    logic        d_write_s = 1'b0;
    logic [31:0] d_addr_s  = '0;
    logic [31:0] d_wdata_s = '0;

    rv_core u_rv_core (
        .clk        (clk),
        .reset      (reset),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    always #50 clk = ~clk;

    //////////////////////////////
    // memory models
    //////////////////////////////

    // ram preload, mixes every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] idx);
        return (idx + 32'd1) * 32'h9e37_79b9;
    endfunction

    always @(negedge clk) begin
        rst_s     <= reset;
        i_req_s   <= imem_req;
        i_addr_s  <= imem_addr;
        d_read_s  <= dmem_read;
        d_write_s <= dmem_write;
        d_addr_s  <= dmem_addr;
        d_wdata_s <= dmem_wdata;
    end

    // one cycle read latency on both sides
    always @(posedge clk) begin
        #1;
        imem_data = i_req_s ? rom[i_addr_s[7:2]] : `NOP_INST;
        if (rst_s) begin
            for (int i = 0; i < 64; i++) begin
                ram[i[5:0]] = fill_word(i);
            end
        end else if (d_write_s) begin
            ram[d_addr_s[7:2]] = d_wdata_s;
        end
        if (d_read_s) begin
            dmem_rdata = ram[d_addr_s[7:2]];
        end
    end

    //////////////////////////////
    // instruction assembly
    //////////////////////////////

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic [6:0] f7,
                                          input int rd, input int rs1, input int rs2);
        logic [31:0] d;
        logic [31:0] a;
        logic [31:0] b;
        d = rd;
        a = rs1;
        b = rs2;
        return {f7, b[4:0], a[4:0], f3, d[4:0], `OP_R};
    endfunction

    // also loads and shift immediates
    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                          input int rd, input int rs1, input int imm);
        logic [31:0] d;
        logic [31:0] a;
        logic [31:0] im;
        d  = rd;
        a  = rs1;
        im = imm;
        return {im[11:0], a[4:0], f3, d[4:0], op};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return enc_i(`OP_IMM, `F3_ADD_SUB, rd, rs1, imm);
    endfunction

    // sw rs2, imm(rs1)
    function automatic logic [31:0] enc_s(input int rs2, input int rs1, input int imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] im;
        a  = rs1;
        b  = rs2;
        im = imm;
        return {im[11:5], b[4:0], a[4:0], 3'b010, im[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                          input int imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] im;
        a  = rs1;
        b  = rs2;
        im = imm;
        return {im[12], im[10:5], b[4:0], a[4:0], f3, im[4:1], im[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input int rd, input int imm);
        logic [31:0] d;
        logic [31:0] im;
        d  = rd;
        im = imm;
        return {im[20], im[10:1], im[11], im[19:12], d[4:0], `OP_JAL};
    endfunction

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    task automatic put_word(input logic [31:0] w);
        prog[n_rows[3:0]][n_words[3:0]] = w;
        n_words++;
    endtask

    task automatic end_row(input logic [31:0] addr, input logic [31:0] data);
        exp_addr[n_rows[3:0]] = addr;
        exp_data[n_rows[3:0]] = data;
        n_rows++;
        n_words = 0;
    endtask

    // not-taken on x1,x3 then taken on x1,x2; x5 counts the path
    task automatic branch_row(input logic [2:0] f3, input int a, input int b, input int c,
                              input int addr);
        put_word(addi(1, 0, a));
        put_word(addi(2, 0, b));
        put_word(addi(3, 0, c));
        put_word(addi(5, 0, 1));
        put_word(enc_b(f3, 1, 3, 16));
        put_word(addi(5, 5, 2));
        put_word(enc_b(f3, 1, 2, 16));
        // two squashed slots, then one never fetched
        put_word(addi(5, 5, 'h40));
        put_word(addi(5, 5, 'h80));
        put_word(addi(5, 5, 'h100));
        put_word(addi(5, 5, 4));
        put_word(enc_s(5, 0, addr));
        end_row(addr, 32'd7);
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [31:0] imm_a;
        logic [31:0] imm_b;
        logic [31:0] imm_c;
        logic [31:0] imm_d;
        logic [31:0] v2;
        logic [31:0] v3;
        logic [31:0] v4;
        logic [31:0] v5;
        logic [31:0] v6;
        for (int i = 0; i < 16; i++) begin
            for (int w = 0; w < WORDS; w++) begin
                prog[i[3:0]][w[3:0]] = `NOP_INST;
            end
        end
        n_rows  = 0;
        n_words = 0;
        // random 12 bit immediates, sign extended
        r     = $urandom;
        imm_a = {{20{r[11]}}, r[11:0]};
        r     = $urandom;
        imm_b = {{20{r[11]}}, r[11:0]};
        r     = $urandom;
        imm_c = {{20{r[11]}}, r[11:0]};
        r     = $urandom;
        imm_d = {{20{r[11]}}, r[11:0]};
        // back to back chain through ex/mem
        put_word(addi(1, 0, imm_a));
        put_word(addi(2, 1, imm_b));
        put_word(enc_r(`F3_ADD_SUB, 7'h00, 3, 2, 1));
        put_word(enc_r(`F3_ADD_SUB, 7'h20, 4, 3, 2));
        put_word(enc_i(`OP_IMM, `F3_XOR, 5, 4, imm_c));
        put_word(enc_r(`F3_OR, 7'h00, 6, 5, 2));
        put_word(enc_i(`OP_IMM, `F3_AND, 7, 6, imm_d));
        put_word(enc_s(7, 0, 'h40));
        v2 = imm_a + imm_b;
        v3 = v2 + imm_a;
        v4 = v3 - v2;
        v5 = v4 ^ imm_c;
        v6 = v5 | v2;
        end_row(32'h40, v6 & imm_d);
        // shifts and compares, srai keeps bit 30 in the imm
        put_word(addi(1, 0, -16));
        put_word(enc_i(`OP_IMM, `F3_SR, 2, 1, 'h402));
        put_word(enc_i(`OP_IMM, `F3_SR, 3, 2, 28));
        put_word(enc_i(`OP_IMM, `F3_SLL, 4, 3, 8));
        put_word(enc_r(`F3_SLT, 7'h00, 5, 2, 4));
        put_word(enc_r(`F3_SLTU, 7'h00, 6, 2, 4));
        put_word(enc_r(`F3_SLL, 7'h00, 7, 5, 3));
        put_word(enc_r(`F3_ADD_SUB, 7'h00, 8, 7, 6));
        put_word(enc_r(`F3_SR, 7'h20, 9, 1, 5));
        put_word(enc_r(`F3_XOR, 7'h00, 10, 8, 9));
        put_word(enc_s(10, 0, 'h44));
        end_row(32'h44, 32'hffff_7ff8);
        // distance 2 and 3 producers
        put_word(addi(1, 0, 100));
        put_word(addi(2, 0, 23));
        put_word(`NOP_INST);
        put_word(enc_r(`F3_ADD_SUB, 7'h00, 3, 1, 2));
        put_word(addi(4, 0, 7));
        put_word(`NOP_INST);
        put_word(enc_r(`F3_ADD_SUB, 7'h20, 5, 3, 4));
        put_word(`NOP_INST);
        put_word(enc_s(5, 0, 'h48));
        end_row(32'h48, 32'd116);
        // load then immediate use, one bubble
        put_word(addi(1, 0, 'h20));
        put_word(enc_i(`OP_LOAD, 3'b010, 2, 1, 8));
        put_word(addi(3, 2, 'h123));
        put_word(enc_s(3, 1, 'h10));
        end_row(32'h30, fill_word(10) + 32'h123);
        // load feeding store data
        put_word(enc_i(`OP_LOAD, 3'b010, 4, 0, 'h3c));
        put_word(enc_s(4, 0, 'h34));
        end_row(32'h34, fill_word(15));
        // signed and unsigned operands per condition
        branch_row(`F3_BEQ, 5, 5, 6, 'h80);
        branch_row(`F3_BNE, 5, 6, 5, 'h84);
        branch_row(`F3_BLT, -3, 2, -4, 'h88);
        branch_row(`F3_BGE, 2, -3, 7, 'h8c);
        branch_row(`F3_BLTU, 5, -1, 3, 'h90);
        branch_row(`F3_BGEU, -2, 7, -1, 'h94);
        // jal at 0x4, link 0x8, skipped code clobbers x6
        put_word(addi(5, 0, 9));
        put_word(enc_j(6, 16));
        put_word(addi(6, 0, 'h55));
        put_word(addi(6, 0, 'h66));
        put_word(addi(6, 6, 'h100));
        put_word(enc_s(6, 0, 'hc0));
        end_row(32'hc0, 32'h8);
        // x0 stays zero even right after a write
        put_word(addi(1, 0, 'h33));
        put_word(addi(0, 1, 'h5a));
        put_word(enc_s(0, 0, 'hd0));
        end_row(32'hd0, 32'h0);
    endtask

    //////////////////////////////
    // checking and row loop
    //////////////////////////////

    task automatic fail_and_stop(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_and_stop($sformatf("MISMATCH at %0d ns: %s got 0x%08h expected 0x%08h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic run_row(input logic [3:0] row);
        int   cycles;
        logic seen;
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (int i = 0; i < 64; i++) begin
            if (i < WORDS) begin
                rom[i[5:0]] = prog[row][i[3:0]];
            end else begin
                rom[i[5:0]] = `NOP_INST;
            end
        end
        repeat (3) @(posedge clk);
        // strobes quiet while reset is held
        @(negedge clk);
        check_value($sformatf("row %0d imem_req in reset", row), imem_req, 32'd0);
        check_value($sformatf("row %0d dmem_read in reset", row), dmem_read, 32'd0);
        check_value($sformatf("row %0d dmem_write in reset", row), dmem_write, 32'd0);
        @(posedge clk);
        #1;
        reset  = 1'b0;
        // first fetch in the cycle after reset falls
        @(negedge clk);
        check_value($sformatf("row %0d first imem_req", row), imem_req, 32'd1);
        check_value($sformatf("row %0d first imem_addr", row), imem_addr, `CORE_RESET_PC);
        cycles = 0;
        seen   = 1'b0;
        // first store marks the end of the row
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            if (dmem_write) begin
                seen = 1'b1;
            end else begin
                cycles++;
            end
        end
        if (!seen) begin
            fail_and_stop($sformatf("row %0d: no store appeared within %0d cycles",
                                    row, TIMEOUT));
        end
        check_value($sformatf("row %0d store address", row), dmem_addr, exp_addr[row]);
        check_value($sformatf("row %0d store data", row), dmem_wdata, exp_data[row]);
    endtask

    initial begin
        logic [31:0] seed_draw;
        seed_draw = $urandom(32'h8411e86d);
        build_table();
        for (int r = 0; r < n_rows; r++) begin
            run_row(r[3:0]);
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module rv_core (
    input  logic             clk,
    input  logic             reset,
    // instruction rom, one cycle read
    output logic             imem_req,
    output logic [`XLEN-1:0] imem_addr,
    input  logic [`XLEN-1:0] imem_data,
    // data ram, one cycle read
    output logic             dmem_read,
    output logic             dmem_write,
    output logic [`XLEN-1:0] dmem_addr,
    output logic [`XLEN-1:0] dmem_wdata,
    input  logic [`XLEN-1:0] dmem_rdata
);

    // stage to stage
    logic                   stall;
    logic                   redirect;
    logic [`XLEN-1:0]       redirect_pc;
    logic [`XLEN-1:0]       fetch_pc;
    logic                   fetch_valid;
    // writeback, to register file and forwarding
    logic                   wb_en;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;

    decode_exec_if de_if ();
    exec_mem_if    em_if ();

    fetch_stage u_fetch (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .fetch_pc    (fetch_pc),
        .fetch_valid (fetch_valid)
    );

    decode_stage u_decode (
        .clk         (clk),
        .reset       (reset),
        .imem_data   (imem_data),
        .fetch_pc    (fetch_pc),
        .fetch_valid (fetch_valid),
        .redirect    (redirect),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .stall       (stall),
        .de          (de_if.stage)
    );

    execute_stage u_execute (
        .clk         (clk),
        .reset       (reset),
        .de          (de_if.exec),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .em          (em_if.stage)
    );

    memory_stage u_memory (
        .clk         (clk),
        .reset       (reset),
        .em          (em_if.mem),
        .dmem_read   (dmem_read),
        .dmem_write  (dmem_write),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_rdata  (dmem_rdata),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

endmodule

`default_nettype wire

// File: hdl/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module memory_stage (
    input  logic                   clk,
    input  logic                   reset,
    exec_mem_if.mem                em,
    output logic                   dmem_read,
    output logic                   dmem_write,
    output logic [`XLEN-1:0]       dmem_addr,
    output logic [`XLEN-1:0]       dmem_wdata,
    input  logic [`XLEN-1:0]       dmem_rdata,
    output logic                   wb_en,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data
);

    // request straight from ex/mem, word wide
    assign dmem_read  = em.valid && em.is_load;
    assign dmem_write = em.valid && em.is_store;
    assign dmem_addr  = em.result;
    assign dmem_wdata = em.store_data;

    //////////////////////////////
    // mem/wb register
    //////////////////////////////

    logic                   mw_reg_write;
    logic                   mw_is_load;
    logic [`REG_ADDR_W-1:0] mw_rd;
    logic [`XLEN-1:0]       mw_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            mw_reg_write <= 1'b0;
            mw_is_load   <= 1'b0;
        end else begin
            mw_reg_write <= em.valid && em.reg_write;
            mw_is_load   <= dmem_read;
        end
    end

    always_ff @(posedge clk) begin
        mw_rd     <= em.rd;
        mw_result <= em.result;
    end

    // read data arrives while the load sits here
    assign wb_en   = mw_reg_write;
    assign wb_rd   = mw_rd;
    assign wb_data = mw_is_load ? dmem_rdata : mw_result;

    // load and store flags come from separate decode paths
    assert property (@(posedge clk) disable iff (reset)
        !(dmem_read && dmem_write))
        else $error("data memory read and write in one cycle");

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   reset,
    decode_exec_if.exec            de,
    input  logic                   wb_en,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]       wb_data,
    output logic                   redirect,
    output logic [`XLEN-1:0]       redirect_pc,
    exec_mem_if.stage              em
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic                   alt;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;

    assign opcode = de.inst.r_fmt.opcode;
    assign funct3 = de.inst.r_fmt.funct3;
    assign alt    = de.inst.r_fmt.funct7[`F7_ALT];
    assign rs1    = de.inst.r_fmt.rs1;
    assign rs2    = de.inst.r_fmt.rs2;

    //////////////////////////////
    // operand forwarding
    //////////////////////////////

    logic             ex_fwd;
    logic             wb_fwd;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;

    // load data is not ready in ex/mem, the stall covers it
    assign ex_fwd = em.valid && em.reg_write && !em.is_load && (em.rd != '0);
    assign wb_fwd = wb_en && (wb_rd != '0);

    // youngest producer first
    assign op_a = (ex_fwd && em.rd == rs1) ? em.result :
                  (wb_fwd && wb_rd == rs1) ? wb_data : de.rs1_data;
    assign op_b = (ex_fwd && em.rd == rs2) ? em.result :
                  (wb_fwd && wb_rd == rs2) ? wb_data : de.rs2_data;

    //////////////////////////////
    // alu
    //////////////////////////////

    logic [`XLEN-1:0] alu_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_y;

    // immediate for everything but r-type
    assign alu_b = (opcode == `OP_R) ? op_b : de.imm;
    assign shamt = alu_b[4:0];

    always_comb begin
        // address add for loads and stores
        alu_y = op_a + alu_b;
        if (opcode == `OP_R || opcode == `OP_IMM) begin
            case (funct3)
                // no subi, alt only in r-type
                `F3_ADD_SUB: alu_y = (opcode == `OP_R && alt) ? op_a - alu_b : op_a + alu_b;
                `F3_SLL:     alu_y = op_a << shamt;
                `F3_SLT:     alu_y = `XLEN'($signed(op_a) < $signed(alu_b));
                `F3_SLTU:    alu_y = `XLEN'(op_a < alu_b);
                `F3_XOR:     alu_y = op_a ^ alu_b;
                // srai keeps alt in the imm field
                `F3_SR:      alu_y = alt ? $unsigned($signed(op_a) >>> shamt) : op_a >> shamt;
                `F3_OR:      alu_y = op_a | alu_b;
                default:     alu_y = op_a & alu_b;
            endcase
        end
    end

    //////////////////////////////
    // branch resolution
    //////////////////////////////

    logic cond;
    logic is_jal;

    always_comb begin
        case (funct3)
            `F3_BEQ:  cond = (op_a == op_b);
            `F3_BNE:  cond = (op_a != op_b);
            `F3_BLT:  cond = ($signed(op_a) < $signed(op_b));
            `F3_BGE:  cond = ($signed(op_a) >= $signed(op_b));
            `F3_BLTU: cond = (op_a < op_b);
            `F3_BGEU: cond = (op_a >= op_b);
            default:  cond = 1'b0;
        endcase
    end

    assign is_jal = (opcode == `OP_JAL);
    // predicted not taken, any taken flow redirects
    assign redirect    = de.valid && (is_jal || (opcode == `OP_BRANCH && cond));
    assign redirect_pc = de.pc + de.imm;

    //////////////////////////////
    // ex/mem register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            em.valid     <= 1'b0;
            em.reg_write <= 1'b0;
            em.is_load   <= 1'b0;
            em.is_store  <= 1'b0;
        end else begin
            em.valid     <= de.valid;
            em.reg_write <= de.reg_write;
            em.is_load   <= de.is_load;
            em.is_store  <= de.valid && (opcode == `OP_STORE);
        end
    end

    // jal links pc+4
    always_ff @(posedge clk) begin
        em.rd         <= de.inst.r_fmt.rd;
        em.result     <= is_jal ? de.pc + `XLEN'd4 : alu_y;
        em.store_data <= op_b;
    end

    // decode must drop the slot behind a taken branch
    assert property (@(posedge clk) disable iff (reset)
        redirect |=> !de.valid)
        else $error("instruction after redirect not squashed");

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`XLEN-1:0]       imem_data,
    input  logic [`XLEN-1:0]       fetch_pc,
    input  logic                   fetch_valid,
    input  logic                   redirect,
    input  logic                   wb_en,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]       wb_data,
    output logic                   stall,
    decode_exec_if.stage           de
);

    //////////////////////////////
    // if/id register
    //////////////////////////////

    logic             ifid_valid;
    logic [`XLEN-1:0] ifid_pc;
    core_pkg::inst_t  ifid_inst;

    // redirect kills the wrong-path slot
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            ifid_valid <= 1'b0;
        end else if (!stall) begin
            ifid_valid <= fetch_valid;
        end
    end

    // empty slots decode as nop
    always_ff @(posedge clk) begin
        if (!stall) begin
            ifid_pc   <= fetch_pc;
            ifid_inst <= fetch_valid ? imem_data : `NOP_INST;
        end
    end

    //////////////////////////////
    // register file
    //////////////////////////////

    logic [`XLEN-1:0]       regs [`NUM_REGS];
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic                   rf_we;

    assign rs1   = ifid_inst.r_fmt.rs1;
    assign rs2   = ifid_inst.r_fmt.rs2;
    // x0 never stored
    assign rf_we = wb_en && (wb_rd != '0);

    always_ff @(posedge clk) begin
        if (rf_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // same-cycle write visible to the reader
    assign rs1_data = (rs1 == '0) ? '0 : (rf_we && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (rf_we && wb_rd == rs2) ? wb_data : regs[rs2];

    //////////////////////////////
    // decode and hazard
    //////////////////////////////

    logic [6:0]             opcode;
    logic [`XLEN-1:0]       imm;
    logic                   writes_rd;
    logic                   uses_rs1;
    logic                   uses_rs2;
    logic [`REG_ADDR_W-1:0] load_rd;

    assign opcode = ifid_inst.r_fmt.opcode;

    always_comb begin
        writes_rd = 1'b0;
        imm       = '0;
        case (opcode)
            `OP_R: writes_rd = 1'b1;
            `OP_IMM, `OP_LOAD: begin
                writes_rd = 1'b1;
                imm = {{20{ifid_inst.i_fmt.imm12[11]}}, ifid_inst.i_fmt.imm12};
            end
            // s-type, imm split over funct7 and rd
            `OP_STORE: imm = {{20{ifid_inst.r_fmt.funct7[6]}}, ifid_inst.r_fmt.funct7,
                              ifid_inst.r_fmt.rd};
            // b-type, bit 11 sits in rd[0]
            `OP_BRANCH: imm = {{19{ifid_inst.r_fmt.funct7[6]}}, ifid_inst.r_fmt.funct7[6],
                               ifid_inst.r_fmt.rd[0], ifid_inst.r_fmt.funct7[5:0],
                               ifid_inst.r_fmt.rd[4:1], 1'b0};
            // j-type, bits 19:12 are rs1 and funct3
            `OP_JAL: begin
                writes_rd = 1'b1;
                imm = {{11{ifid_inst.r_fmt.funct7[6]}}, ifid_inst.r_fmt.funct7[6],
                       ifid_inst.r_fmt.rs1, ifid_inst.r_fmt.funct3, ifid_inst.r_fmt.rs2[0],
                       ifid_inst.r_fmt.funct7[5:0], ifid_inst.r_fmt.rs2[4:1], 1'b0};
            end
            default: writes_rd = 1'b0;
        endcase
    end

    // only real source fields count for the hazard
    assign uses_rs1 = (opcode != `OP_JAL);
    assign uses_rs2 = (opcode == `OP_R) || (opcode == `OP_STORE) || (opcode == `OP_BRANCH);

    // load in id/ex feeding the slot in if/id
    assign load_rd = de.inst.r_fmt.rd;
    assign stall   = de.valid && de.is_load && (load_rd != '0) && ifid_valid &&
                     ((uses_rs1 && load_rd == rs1) || (uses_rs2 && load_rd == rs2));

    //////////////////////////////
    // id/ex register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || redirect || stall) begin
            de.valid     <= 1'b0;
            de.reg_write <= 1'b0;
            de.is_load   <= 1'b0;
        end else begin
            de.valid     <= ifid_valid;
            de.reg_write <= ifid_valid && writes_rd;
            de.is_load   <= ifid_valid && (opcode == `OP_LOAD);
        end
    end

    always_ff @(posedge clk) begin
        de.pc       <= ifid_pc;
        de.inst     <= ifid_inst;
        de.imm      <= imm;
        de.rs1_data <= rs1_data;
        de.rs2_data <= rs2_data;
    end

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module fetch_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirect_pc,
    output logic             imem_req,
    output logic [`XLEN-1:0] imem_addr,
    output logic [`XLEN-1:0] fetch_pc,
    output logic             fetch_valid
);

    // pc is being requested, prev_pc is the word on imem_data
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] prev_pc;
    logic [`XLEN-1:0] next_pc;
    // request last cycle, not squashed
    logic             in_flight;

    // redirect first, then hold, else sequential
    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (stall) begin
            next_pc = pc;
        end else begin
            next_pc = pc + `XLEN'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CORE_RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // one behind pc, frozen with the stalled slot
    always_ff @(posedge clk) begin
        if (!stall) begin
            prev_pc <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= 1'b0;
        end else begin
            in_flight <= imem_req;
        end
    end

    // no fetch in reset
    // a word asked for during redirect is wrong path
    assign imem_req    = !reset && !redirect;
    // word arriving under stall is dropped by decode, ask again
    assign imem_addr   = stall ? prev_pc : pc;
    assign fetch_pc    = prev_pc;
    assign fetch_valid = in_flight;

    // targets computed in execute must land on a word
    assert property (@(posedge clk) disable iff (reset)
        redirect |-> (redirect_pc[1:0] == 2'b00))
        else $error("redirect target not word aligned");

endmodule

`default_nettype wire

// File: hdl/pipe_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

//////////////////////////////
// id/ex register contents
//////////////////////////////

interface decode_exec_if;
    logic             valid;
    logic [`XLEN-1:0] pc;
    core_pkg::inst_t  inst;
    // already sign extended per format
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic             reg_write;
    logic             is_load;

    // decode owns the register
    modport stage (
        output valid, pc, inst, imm, rs1_data, rs2_data, reg_write, is_load
    );
    // execute only looks
    modport exec (
        input valid, pc, inst, imm, rs1_data, rs2_data, reg_write, is_load
    );
endinterface

//////////////////////////////
// ex/mem register contents
//////////////////////////////

interface exec_mem_if;
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   reg_write;
    logic                   is_load;
    logic                   is_store;
    // alu result or link address
    logic [`XLEN-1:0]       result;
    logic [`XLEN-1:0]       store_data;

    modport stage (
        output valid, rd, reg_write, is_load, is_store, result, store_data
    );
    modport mem (
        input valid, rd, reg_write, is_load, is_store, result, store_data
    );
endinterface

`default_nettype wire

// File: hdl/core_pkg.sv
`default_nettype none
`include "core_defs.svh"

package core_pkg;

    // one instruction word seen two ways
    // s, b and j immediates are rebuilt from the r_fmt fields
    typedef union packed {
        // register-register layout
        struct packed {
            logic [6:0]             funct7;
            logic [`REG_ADDR_W-1:0] rs2;
            logic [`REG_ADDR_W-1:0] rs1;
            logic [2:0]             funct3;
            logic [`REG_ADDR_W-1:0] rd;
            logic [6:0]             opcode;
        } r_fmt;
        // alu immediate and load layout
        struct packed {
            logic [11:0]            imm12;
            logic [`REG_ADDR_W-1:0] rs1;
            logic [2:0]             funct3;
            logic [`REG_ADDR_W-1:0] rd;
            logic [6:0]             opcode;
        } i_fmt;
    } inst_t;

endpackage

`default_nettype wire

// File: hdl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and register file sizes
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// first fetch address out of reset
`define CORE_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INST    32'h0000_0013

// major opcodes, inst[6:0]
`define OP_R        7'b0110011
`define OP_IMM      7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111

// branch conditions
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

// alu operations, shared by r-type and immediate forms
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct7 bit index for sub and sra
`define F7_ALT      5

`endif
